// File: dbg_pkg.sv
package dbg_pkg;

    // UART and instruction word geometry
    localparam int BYTE_W       = 8;
    localparam int WORD_W       = 32;
    localparam int INSTR_BYTES  = 4;                    // MSB first on the wire
    localparam logic [WORD_W-1:0] INSTR_STRIDE = 32'd4;
    localparam logic [WORD_W-1:0] HALT_WORD    = '1;    // Last word of a program

    // Pipeline segment widths in dump order
    localparam int ID_EX_W  = 144;
    localparam int EX_MEM_W = 32;
    localparam int MEM_WB_W = 48;
    localparam int WB_ID_W  = 40;
    localparam int CTRL_W   = 24;

    localparam int SNAP_BYTES = (ID_EX_W + EX_MEM_W + MEM_WB_W + WB_ID_W + CTRL_W) / BYTE_W;

    // Single-byte commands
    localparam logic [BYTE_W-1:0] CMD_LOAD  = 8'h01;
    localparam logic [BYTE_W-1:0] CMD_DEBUG = 8'h02;
    localparam logic [BYTE_W-1:0] CMD_RUN   = 8'h04;
    localparam logic [BYTE_W-1:0] CMD_STEP  = 8'h08;
    localparam logic [BYTE_W-1:0] CMD_END   = 8'h10;

    typedef struct packed {
        logic [BYTE_W-1:0] data;
        logic              done;                        // Byte valid this cycle
    } rx_byte_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] addr;
        logic [WORD_W-1:0] instr;
    } instr_write_t;

    // First field sits at the top, so a left shift walks it in dump order
    typedef struct packed {
        logic [ID_EX_W-1:0]  id_ex;
        logic [EX_MEM_W-1:0] ex_mem;
        logic [MEM_WB_W-1:0] mem_wb;
        logic [WB_ID_W-1:0]  wb_id;
        logic [CTRL_W-1:0]   ctrl;                      // ID/EX control bits
    } pipe_snapshot_t;

endpackage

// File: dbg_mode_ctrl.sv
`timescale 1ns/1ps

module dbg_mode_ctrl
    import dbg_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst_n,
    input  rx_byte_t i_rx,
    input  logic     i_end,
    input  logic     i_halt_seen,
    input  logic     i_dump_done,
    output logic     o_load_active,
    output logic     o_dump_start,
    output logic     o_step,
    output logic     o_start
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_DEBUG,
        S_RUN,
        S_DUMP
    } mode_t;

    mode_t state;
    logic  back_to_debug;                               // Where a dump returns to

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state         <= S_IDLE;
            back_to_debug <= 1'b0;
            o_load_active <= 1'b0;
            o_dump_start  <= 1'b0;
            o_step        <= 1'b0;
            o_start       <= 1'b0;
        end else begin
            o_dump_start <= 1'b0;                       // Single-cycle pulse
            case (state)
                S_IDLE: begin
                    if (i_rx.done) begin
                        case (i_rx.data)
                            CMD_LOAD: begin
                                state         <= S_LOAD;
                                o_load_active <= 1'b1;
                            end
                            CMD_DEBUG: begin
                                state   <= S_DEBUG;
                                o_start <= 1'b1;
                            end
                            CMD_RUN: begin
                                state   <= S_RUN;
                                o_start <= 1'b1;
                                o_step  <= 1'b1;        // Held for the whole run
                            end
                            default: begin
                                state <= S_IDLE;        // Other bytes are ignored
                            end
                        endcase
                    end
                end

                S_LOAD: begin
                    // Loader owns the RX bytes until the halt word is written
                    if (i_halt_seen) begin
                        state         <= S_IDLE;
                        o_load_active <= 1'b0;
                    end
                end

                S_DEBUG: begin
                    if (i_rx.done) begin
                        case (i_rx.data)
                            CMD_STEP: begin
                                o_step        <= 1'b1;
                                o_dump_start  <= 1'b1;
                                back_to_debug <= 1'b1;
                                state         <= S_DUMP;
                            end
                            CMD_END: begin
                                o_dump_start  <= 1'b1;
                                back_to_debug <= 1'b0;
                                state         <= S_DUMP;
                            end
                            default: begin
                                state <= S_DEBUG;
                            end
                        endcase
                    end
                end

                S_RUN: begin
                    if (i_end) begin
                        o_step        <= 1'b0;
                        o_dump_start  <= 1'b1;
                        back_to_debug <= 1'b0;
                        state         <= S_DUMP;
                    end
                end

                S_DUMP: begin
                    o_step <= 1'b0;                     // Ends the step pulse
                    if (i_dump_done) begin
                        if (back_to_debug) begin
                            state <= S_DEBUG;
                        end else begin
                            state   <= S_IDLE;
                            o_start <= 1'b0;
                        end
                    end
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// File: dbg_instr_loader.sv
`timescale 1ns/1ps

module dbg_instr_loader
    import dbg_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    input  rx_byte_t     i_rx,
    input  logic         i_load_active,
    output instr_write_t o_instr_wr,
    output logic         o_halt_seen
);

    logic [$clog2(INSTR_BYTES)-1:0] byte_cnt;
    logic [WORD_W-BYTE_W-1:0]       partial;            // Upper bytes received so far
    logic [WORD_W-1:0]              addr;
    logic [WORD_W-1:0]              word_next;
    logic                           take_byte;
    logic                           last_byte;
    logic                           wr_valid;
    logic [WORD_W-1:0]              wr_addr;
    logic [WORD_W-1:0]              wr_instr;

    assign word_next = {partial, i_rx.data};
    assign take_byte = i_load_active && i_rx.done;
    assign last_byte = take_byte &&
                       (byte_cnt == ($clog2(INSTR_BYTES))'(INSTR_BYTES - 1));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            byte_cnt    <= '0;
            addr        <= '0;
            wr_valid    <= 1'b0;
            o_halt_seen <= 1'b0;
        end else begin
            wr_valid    <= 1'b0;
            o_halt_seen <= 1'b0;
            if (!i_load_active) begin
                byte_cnt <= '0;                         // Next load starts at address 0
                addr     <= '0;
            end else if (take_byte) begin
                byte_cnt <= byte_cnt + 1'b1;            // Wraps after the fourth byte
                if (last_byte) begin
                    wr_valid    <= 1'b1;
                    o_halt_seen <= (word_next == HALT_WORD);
                    addr        <= addr + INSTR_STRIDE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_byte) begin
            partial <= word_next[WORD_W-BYTE_W-1:0];
        end
        if (last_byte) begin
            wr_addr  <= addr;
            wr_instr <= word_next;
        end
    end

    assign o_instr_wr = '{valid: wr_valid, addr: wr_addr, instr: wr_instr};

endmodule

// File: dbg_snapshot_sender.sv
`timescale 1ns/1ps

module dbg_snapshot_sender
    import dbg_pkg::*;
(
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_dump_start,
    input  pipe_snapshot_t    i_snapshot,
    input  logic              i_tx_done,
    output logic              o_tx_start,
    output logic [BYTE_W-1:0] o_tx_data,
    output logic              o_dump_done
);

    pipe_snapshot_t                   snap_q;           // Shifts up one byte per send
    logic [$clog2(SNAP_BYTES+1)-1:0]  sent;             // Bytes started so far
    logic                             busy;
    logic                             all_sent;

    assign all_sent = (sent == ($clog2(SNAP_BYTES+1))'(SNAP_BYTES));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            sent        <= '0;
            busy        <= 1'b0;
            o_tx_start  <= 1'b0;
            o_dump_done <= 1'b0;
        end else begin
            o_tx_start  <= 1'b0;
            o_dump_done <= 1'b0;
            if (i_dump_start) begin
                busy       <= 1'b1;
                sent       <= ($clog2(SNAP_BYTES+1))'(1);
                o_tx_start <= 1'b1;                     // First byte right after the latch
            end else if (busy && i_tx_done) begin
                if (all_sent) begin
                    busy        <= 1'b0;
                    o_dump_done <= 1'b1;
                end else begin
                    sent       <= sent + 1'b1;
                    o_tx_start <= 1'b1;
                end
            end
        end
    end

    // Snapshot payload
    always_ff @(posedge clk) begin
        if (i_dump_start) begin
            snap_q <= i_snapshot;
        end else if (busy && i_tx_done && !all_sent) begin
            snap_q <= snap_q << BYTE_W;
        end
    end

    // Top byte is stable from each start pulse until its tx done
    assign o_tx_data = snap_q[SNAP_BYTES*BYTE_W-1 -: BYTE_W];

endmodule

// File: debug_unit.sv
`timescale 1ns/1ps

module debug_unit
    import dbg_pkg::*;
(
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic [BYTE_W-1:0] i_rx_data,
    input  logic              i_rx_done,
    input  logic              i_tx_done,
    input  logic              i_end,
    input  pipe_snapshot_t    i_snapshot,
    output logic              o_tx_start,
    output logic [BYTE_W-1:0] o_tx_data,
    output instr_write_t      o_instr_wr,
    output logic              o_step,
    output logic              o_start
);

    rx_byte_t rx;
    logic     load_active;
    logic     halt_seen;
    logic     dump_start;
    logic     dump_done;

    assign rx = '{data: i_rx_data, done: i_rx_done};

    dbg_mode_ctrl mode_ctrl_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_rx          (rx),
        .i_end         (i_end),
        .i_halt_seen   (halt_seen),
        .i_dump_done   (dump_done),
        .o_load_active (load_active),
        .o_dump_start  (dump_start),
        .o_step        (o_step),
        .o_start       (o_start)
    );

    dbg_instr_loader instr_loader_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_rx          (rx),
        .i_load_active (load_active),
        .o_instr_wr    (o_instr_wr),
        .o_halt_seen   (halt_seen)
    );

    dbg_snapshot_sender snapshot_sender_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_dump_start (dump_start),
        .i_snapshot   (i_snapshot),
        .i_tx_done    (i_tx_done),
        .o_tx_start   (o_tx_start),
        .o_tx_data    (o_tx_data),
        .o_dump_done  (dump_done)
    );

endmodule

// File: debug_unit_chk.sv
`timescale 1ns/1ps

module debug_unit_chk (
    input logic clk,
    input logic i_rst_n,
    input logic i_tx_start,
    input logic i_wr_valid,
    input logic i_step,
    input logic i_start
);

    tx_start_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_tx_start |=> !i_tx_start)
        else $error("tx start held high for more than one cycle");

    wr_valid_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wr_valid |=> !i_wr_valid)
        else $error("instruction write held high for more than one cycle");

    // Step only makes sense while the processor is started
    step_needs_start: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_step |-> i_start)
        else $error("step high while start is low");

    reset_clears: assert property (@(posedge clk)
        !i_rst_n |=> !(i_tx_start || i_wr_valid || i_step || i_start))
        else $error("control output high in the cycle after reset");

endmodule

bind debug_unit debug_unit_chk chk_i (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_tx_start (o_tx_start),
    .i_wr_valid (o_instr_wr.valid),
    .i_step     (o_step),
    .i_start    (o_start)
);

// File: tb_debug_unit.sv
`timescale 1ns/1ps

module tb_debug_unit
    import dbg_pkg::*;
();

    logic              clk = 1'b0;
    logic              rst_n;
    logic [BYTE_W-1:0] rx_data;
    logic              rx_done;
    logic              tx_done = 1'b0;
    logic              end_in;
    pipe_snapshot_t    snapshot;
    logic              tx_start;
    logic [BYTE_W-1:0] tx_data;
    instr_write_t      instr_wr;
    logic              step;
    logic              start;

    logic [31:0]       lfsr = 32'h49aeef36;             // Stimulus stream
    logic [31:0]       resp_lfsr = 32'h49aeef36;        // Transmitter delay stream
    int                tx_wait = 0;
    int                tx_acks = 0;
    int                step_cycles = 0;
    logic [BYTE_W-1:0] tx_bytes[$];
    logic [WORD_W-1:0] wr_addrs[$];
    logic [WORD_W-1:0] wr_instrs[$];
    logic [BYTE_W-1:0] exp_bytes[$];
    pipe_snapshot_t    snap_model;

    debug_unit dut_i (
        .clk        (clk),
        .i_rst_n    (rst_n),
        .i_rx_data  (rx_data),
        .i_rx_done  (rx_done),
        .i_tx_done  (tx_done),
        .i_end      (end_in),
        .i_snapshot (snapshot),
        .o_tx_start (tx_start),
        .o_tx_data  (tx_data),
        .o_instr_wr (instr_wr),
        .o_step     (step),
        .o_start    (start)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(rand_bits(8)) % (hi - lo + 1);
    endfunction

    // UART transmitter model that pulses done 1 to 8 cycles after each start
    always @(negedge clk) begin
        logic [2:0] delay;
        tx_done = 1'b0;
        if (tx_wait > 0) begin
            tx_wait = tx_wait - 1;
            if (tx_wait == 0) begin
                tx_done = 1'b1;
                tx_acks = tx_acks + 1;
            end
        end
        if (tx_start) begin
            tx_bytes.push_back(tx_data);
            delay = '0;
            for (int i = 0; i < 3; i++) begin
                resp_lfsr = lfsr_next(resp_lfsr);
                delay = {delay[1:0], resp_lfsr[0]};
            end
            tx_wait = int'(delay) + 1;
        end
    end

    always @(posedge clk) begin
        if (instr_wr.valid) begin
            wr_addrs.push_back(instr_wr.addr);
            wr_instrs.push_back(instr_wr.instr);
        end
        if (step) begin
            step_cycles = step_cycles + 1;
        end
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %08h actual %08h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        abort_run();
    endtask

    // Random gap of 0 to 3 cycles, then a single-cycle done strobe
    task automatic send_byte(input logic [BYTE_W-1:0] b);
        repeat (int'(rand_bits(2))) @(negedge clk);
        rx_data = b;
        rx_done = 1'b1;
        @(negedge clk);
        rx_done = 1'b0;
    endtask

    task automatic new_snapshot();
        logic [SNAP_BYTES*BYTE_W-1:0] bits;
        bits = '0;
        for (int i = 0; i < SNAP_BYTES; i++) begin
            bits = {bits[SNAP_BYTES*BYTE_W-BYTE_W-1:0], 8'(rand_bits(8))};
        end
        snap_model = bits;
        snapshot   = bits;
    endtask

    task automatic push_segment(input logic [ID_EX_W-1:0] v, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin
            exp_bytes.push_back(v[i*BYTE_W +: BYTE_W]);     // MSB first
        end
    endtask

    task automatic check_dump(input string name, input int byte_base);
        exp_bytes.delete();
        push_segment(snap_model.id_ex, ID_EX_W / BYTE_W);
        push_segment((ID_EX_W)'(snap_model.ex_mem), EX_MEM_W / BYTE_W);
        push_segment((ID_EX_W)'(snap_model.mem_wb), MEM_WB_W / BYTE_W);
        push_segment((ID_EX_W)'(snap_model.wb_id), WB_ID_W / BYTE_W);
        push_segment((ID_EX_W)'(snap_model.ctrl), CTRL_W / BYTE_W);
        check({name, " byte count"}, 32'(exp_bytes.size()), 32'(tx_bytes.size() - byte_base));
        for (int i = 0; i < exp_bytes.size(); i++) begin
            check($sformatf("%s byte %0d", name, i), 32'(exp_bytes[i]),
                  32'(tx_bytes[byte_base + i]));
        end
    endtask

    task automatic wait_writes(input int target);
        int t;
        t = 0;
        while (wr_addrs.size() < target) begin
            if (t >= 100) report_timeout("instruction write");
            @(negedge clk);
            t++;
        end
    endtask

    task automatic wait_dump(input int ack_target, input string what);
        int t;
        t = 0;
        @(posedge clk);
        while (tx_acks < ack_target) begin
            if (t >= 1000) report_timeout(what);
            @(posedge clk);
            t++;
        end
        repeat (3) @(negedge clk);                          // Let the mode settle
    endtask

    task automatic send_ignored(input string where, input int count);
        int   wr_base;
        int   step_base;
        int   byte_base;
        logic start_before;
        wr_base      = wr_addrs.size();
        step_base    = step_cycles;
        byte_base    = tx_bytes.size();
        start_before = start;
        for (int i = 0; i < count; i++) begin
            send_byte(8'(rand_bits(8)) | 8'h20);            // Never a command code
        end
        repeat (4) @(negedge clk);
        check({where, " writes"}, 32'(wr_base), 32'(wr_addrs.size()));
        check({where, " steps"}, 32'(step_base), 32'(step_cycles));
        check({where, " dump bytes"}, 32'(byte_base), 32'(tx_bytes.size()));
        check({where, " start"}, 32'(start_before), 32'(start));
    endtask

    task automatic run_load();
        logic [WORD_W-1:0] words[$];
        logic [WORD_W-1:0] w;
        int                n;
        int                base;
        n = rand_range(2, 6);
        for (int i = 0; i < n; i++) begin
            w = rand_bits(32);
            words.push_back((w == HALT_WORD) ? 32'h0 : w);
        end
        words.push_back(HALT_WORD);
        base = wr_addrs.size();
        send_byte(CMD_LOAD);
        foreach (words[i]) begin
            for (int k = INSTR_BYTES - 1; k >= 0; k--) begin
                send_byte(words[i][k*BYTE_W +: BYTE_W]);
            end
        end
        wait_writes(base + words.size());
        repeat (2) @(negedge clk);
        check("load write count", 32'(words.size()), 32'(wr_addrs.size() - base));
        foreach (words[i]) begin
            check($sformatf("load addr %0d", i), 32'(4 * i), wr_addrs[base + i]);
            check($sformatf("load instr %0d", i), words[i], wr_instrs[base + i]);
        end
    endtask

    initial begin
        int byte_base;
        int ack_base;
        int step_base;
        rst_n    = 1'b0;
        rx_data  = '0;
        rx_done  = 1'b0;
        end_in   = 1'b0;
        snapshot = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check("reset write valid", 32'h0, 32'(instr_wr.valid));
        check("reset tx start", 32'h0, 32'(tx_start));
        check("reset step", 32'h0, 32'(step));
        check("reset start", 32'h0, 32'(start));

        send_ignored("idle", rand_range(2, 5));
        run_load();

        send_byte(CMD_DEBUG);
        check("debug start", 32'h1, 32'(start));
        send_ignored("debug", rand_range(2, 5));
        repeat (rand_range(1, 4)) begin
            new_snapshot();
            byte_base = tx_bytes.size();
            ack_base  = tx_acks;
            step_base = step_cycles;
            send_byte(CMD_STEP);
            wait_dump(ack_base + SNAP_BYTES, "step dump");
            check("step pulses", 32'h1, 32'(step_cycles - step_base));
            check_dump("step dump", byte_base);
            check("start while stepping", 32'h1, 32'(start));
        end

        new_snapshot();
        byte_base = tx_bytes.size();
        ack_base  = tx_acks;
        step_base = step_cycles;
        send_byte(CMD_END);
        wait_dump(ack_base + SNAP_BYTES, "end dump");
        check("end step pulses", 32'h0, 32'(step_cycles - step_base));
        check_dump("end dump", byte_base);
        check("start after end", 32'h0, 32'(start));
        run_load();

        new_snapshot();
        byte_base = tx_bytes.size();
        ack_base  = tx_acks;
        send_byte(CMD_RUN);
        check("run start", 32'h1, 32'(start));
        repeat (rand_range(2, 20)) begin
            check("run step level", 32'h1, 32'(step));
            @(negedge clk);
        end
        end_in = 1'b1;
        @(negedge clk);
        end_in = 1'b0;
        check("step after end of program", 32'h0, 32'(step));
        wait_dump(ack_base + SNAP_BYTES, "run dump");
        check_dump("run dump", byte_base);
        check("step after run", 32'h0, 32'(step));
        check("start after run", 32'h0, 32'(start));

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: files.f
dbg_pkg.sv
dbg_mode_ctrl.sv
dbg_instr_loader.sv
dbg_snapshot_sender.sv
debug_unit.sv
debug_unit_chk.sv
tb_debug_unit.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -f files.f --top-module tb_debug_unit -o sim_tb

out=$(./obj_dir/sim_tb 2>&1 || true)
echo "$out"
echo "$out" | grep -q "TEST PASSED"
